/* tb/a8_io_patterns.txt */
// Columns (hex): op a b c d e. op 1 host write a bytes, 2 host read a bytes,
// 3 block drv=a wr=b lba=c mask=d, 4 mount slot=a attr=b size=c fileno=d ro=e,
// 5 mouse dx=a dy=b flags=c x=d y=e, 6 takeover joya=a halt=b, 0 end
// Mount attr bit 2 is the read-only input, bits 1:0 the type
// Mouse flags bits 15:8 packet count, bit 4 Y inversion, bits 1:0 buttons
1 10 0 0 0 0
1 3 0 0 0 0
2 20 0 0 0 0
3 0 0 1234 1 0
3 5 1 deadbeef 8 0
3 4 0 00c0ffee 4 0
3 1 1 0000a5a5 2 0
4 0 1 16810 0 0
4 1 6 23000 1 1
4 2 0 1000 4 1
4 3 3 b4000 5 1
5 05 fd 101 05 fd
5 14 ec 112 0f 07
5 7f 80 c03 7f 8f
5 0a f6 200 7f 80
6 3412 0 0 0 0
5 f9 09 111 f9 f7
6 0 1 0 0 0
0 0 0 0 0 0

/* flist.f */
+incdir+hdl
hdl/a8_io_pkg.sv
hdl/buf_port_if.sv
hdl/sector_buffer.sv
hdl/host_mailbox.sv
hdl/mount_tracker.sv
hdl/mouse_axis.sv
hdl/a8_io_top.sv
tb/tb_clock.sv
tb/tb_a8_io.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the a8_io testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f flist.f --top-module tb_a8_io --Mdir obj_dir -o sim_a8_io \
	&& ./obj_dir/sim_a8_io > sim.log 2>&1 \
	|| { echo "Build or simulation error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Verification failed" sim.log && { echo "Simulation reported a failure"; exit 1; }
grep -q "Verification passed" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0

/* tb/tb_a8_io.sv */
// Testbench for a8_io_top with pattern file operations, checks and result report
`timescale 1ns/1ps
`include "a8_io_params.svh"

module tb_a8_io;

	import a8_io_pkg::*;

	localparam int PAT_COLS   = 6;
	localparam int PAT_LINES  = 32;
	localparam int WAIT_LIMIT = 200;
	localparam int BUF_DEPTH  = 1 << `A8_BUF_AW;
	localparam logic [13:0] JOY_IDLE = 14'h1e5a;

	logic         clk_sys;
	logic         areset;
	host_ctrl_t   host_ctrl;
	logic [31:0]  host_data_i;
	logic         host_data_wr_i;
	logic         host_data_rd_i;
	logic         host_io_wr_i;
	host_status_t host_status_o;
	logic [31:0]  host_data_o;
	logic [31:0]  sd_lba_o;
	logic [3:0]   sd_rd_o;
	logic [3:0]   sd_wr_o;
	logic [3:0]   sd_ack_i;
	logic [8:0]   sd_buff_addr_i;
	logic [7:0]   sd_buff_dout_i;
	logic         sd_buff_wr_i;
	logic [7:0]   sd_buff_din_o;
	logic [3:0]   img_mounted_i;
	logic         img_readonly_i;
	logic [1:0]   img_type_i;
	logic [31:0]  img_size_i;
	mouse_pkt_t   mouse_pkt;
	logic         mouse_invert_y_i;
	logic [15:0]  joya_i;
	logic [13:0]  joy_i;
	logic         cpu_halt_i;
	logic [7:0]   axis_x_o;
	logic [7:0]   axis_y_o;
	logic [13:0]  joy_o;

	logic [31:0] pat [PAT_LINES*PAT_COLS];
	logic [7:0]  bytes_q [BUF_DEPTH];
	logic [31:0] seed_word;
	logic [31:0] op;
	logic        timed_out;
	logic        exp_mounted;
	logic        run_done;
	int          errors;
	int          tests_run;
	int          tests_failed;
	int          err_before;
	int          pat_line;
	int          base;

	tb_clock #(.PERIOD_NS(4.0)) u_clock (.clk_o(clk_sys));

	a8_io_top dut (
		.clk_sys          (clk_sys),
		.areset           (areset),
		.host_ctrl_i      (host_ctrl),
		.host_data_i      (host_data_i),
		.host_data_wr_i   (host_data_wr_i),
		.host_data_rd_i   (host_data_rd_i),
		.host_io_wr_i     (host_io_wr_i),
		.host_status_o    (host_status_o),
		.host_data_o      (host_data_o),
		.sd_lba_o         (sd_lba_o),
		.sd_rd_o          (sd_rd_o),
		.sd_wr_o          (sd_wr_o),
		.sd_ack_i         (sd_ack_i),
		.sd_buff_addr_i   (sd_buff_addr_i),
		.sd_buff_dout_i   (sd_buff_dout_i),
		.sd_buff_wr_i     (sd_buff_wr_i),
		.sd_buff_din_o    (sd_buff_din_o),
		.img_mounted_i    (img_mounted_i),
		.img_readonly_i   (img_readonly_i),
		.img_type_i       (img_type_i),
		.img_size_i       (img_size_i),
		.mouse_pkt_i      (mouse_pkt),
		.mouse_invert_y_i (mouse_invert_y_i),
		.joya_i           (joya_i),
		.joy_i            (joy_i),
		.cpu_halt_i       (cpu_halt_i),
		.axis_x_o         (axis_x_o),
		.axis_y_o         (axis_y_o),
		.joy_o            (joy_o)
	);

	// ==============================
	// Helpers
	// ==============================

	// Inputs change 1 ns after the rising edge
	task automatic tick();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("CHECK FAILED time %0t %s got %h expected %h", $time, name, got, exp);
		errors++;
	endtask

	// Sel picks any block request (0), io_done (1) or the mounted flag (2)
	function automatic logic [31:0] probe(input int sel);
		case (sel)
			0: return 32'(|{sd_wr_o, sd_rd_o});
			1: return 32'(host_status_o.io_done);
			default: return 32'(host_status_o.mounted);
		endcase
	endfunction

	task automatic wait_until(input int sel, input logic [31:0] want, input string desc);
		int n;
		n = 0;
		while (probe(sel) !== want && n < WAIT_LIMIT) begin
			tick();
			n++;
		end
		if (probe(sel) !== want) begin
			$display("Timeout while waiting for %s at time %0t", desc, $time);
			errors++;
			timed_out = 1'b1;
		end
	endtask

	function automatic string op_name(input logic [31:0] code);
		case (code)
			32'h1: return "host write";
			32'h2: return "host read";
			32'h3: return "block request";
			32'h4: return "mount";
			32'h5: return "mouse packet";
			32'h6: return "joystick takeover";
			default: return "unknown";
		endcase
	endfunction

	task automatic pulse_io_wr();
		host_io_wr_i = 1'b1;
		tick();
		host_io_wr_i = 1'b0;
	endtask

	// Four cycles per strobe with the data held throughout
	task automatic host_write_word(input logic [31:0] data);
		host_data_i    = data;
		host_data_wr_i = 1'b1;
		tick();
		tick();
		host_data_wr_i = 1'b0;
		tick();
		tick();
	endtask

	// ==============================
	// Test operations
	// ==============================

	task automatic host_write_readback(input int n);
		logic [31:0] rnd;
		if (n > BUF_DEPTH) begin
			$display("Byte count %0d does not fit in the sector buffer", n);
			errors++;
			return;
		end
		host_ctrl = '0;
		pulse_io_wr();
		for (int k = 0; k < n; k++) begin
			rnd        = $urandom();
			bytes_q[k] = rnd[7:0];
			host_write_word(rnd);
		end
		for (int k = 0; k < n; k++) begin
			sd_buff_addr_i = k[8:0];
			tick();
			if (sd_buff_din_o !== bytes_q[k]) begin
				report_mismatch("sd_buff_din_o", 32'(sd_buff_din_o), 32'(bytes_q[k]));
			end
		end
	endtask

	task automatic host_read_sequence(input int n);
		logic [31:0] rnd;
		if (n > BUF_DEPTH) begin
			$display("Byte count %0d does not fit in the sector buffer", n);
			errors++;
			return;
		end
		host_ctrl = '0;
		for (int k = 0; k < n; k++) begin
			rnd            = $urandom();
			bytes_q[k]     = rnd[7:0];
			sd_buff_addr_i = k[8:0];
			sd_buff_dout_i = rnd[7:0];
			sd_buff_wr_i   = 1'b1;
			tick();
		end
		sd_buff_wr_i = 1'b0;
		pulse_io_wr();
		tick();
		for (int k = 0; k < n; k++) begin
			if (host_data_o !== 32'(bytes_q[k])) begin
				report_mismatch("host_data_o", host_data_o, 32'(bytes_q[k]));
			end
			host_data_rd_i = 1'b1;
			tick();
			host_data_rd_i = 1'b0;
			tick();
			tick();
		end
	endtask

	task automatic block_request_cycle(input logic [2:0] drv, input logic is_wr,
		input logic [31:0] lba, input logic [3:0] mask);
		logic [7:0] want;
		want = is_wr ? {mask, 4'h0} : {4'h0, mask};
		host_ctrl         = '0;
		host_ctrl.lba_sel = 1'b1;
		host_write_word(lba);
		if (sd_lba_o !== lba) begin
			report_mismatch("sd_lba_o", sd_lba_o, lba);
		end
		host_ctrl          = '0;
		host_ctrl.drv_num  = drv;
		host_ctrl.block_rd = ~is_wr;
		host_ctrl.block_wr = is_wr;
		wait_until(0, 32'h1, "a block request");
		if (timed_out) begin
			return;
		end
		if ({sd_wr_o, sd_rd_o} !== want) begin
			report_mismatch("sd_wr_o/sd_rd_o", 32'({sd_wr_o, sd_rd_o}), 32'(want));
		end
		if (host_status_o.io_done !== 1'b0) begin
			report_mismatch("io_done", 32'(host_status_o.io_done), 32'h0);
		end
		sd_ack_i = mask;
		wait_until(0, 32'h0, "the request bits to clear");
		if (timed_out) begin
			return;
		end
		// The SD side keeps the ack a while longer
		repeat (3) tick();
		if (host_status_o.io_done !== 1'b0) begin
			report_mismatch("io_done", 32'(host_status_o.io_done), 32'h0);
		end
		sd_ack_i = '0;
		wait_until(1, 32'h1, "io_done");
		host_ctrl = '0;
		tick();
	endtask

	task automatic mount_image(input int slot, input logic [31:0] attr,
		input logic [31:0] size, input logic [31:0] exp_fileno, input logic [31:0] exp_ro);
		exp_mounted    = ~exp_mounted;
		img_mounted_i  = 4'(1 << slot);
		img_type_i     = attr[1:0];
		img_readonly_i = attr[2];
		img_size_i     = size;
		wait_until(2, 32'(exp_mounted), "the mounted flag to toggle");
		img_mounted_i = '0;
		if (timed_out) begin
			return;
		end
		if (host_status_o.fileno !== exp_fileno[2:0]) begin
			report_mismatch("fileno", 32'(host_status_o.fileno), exp_fileno);
		end
		if (host_status_o.filetype !== attr[1:0]) begin
			report_mismatch("filetype", 32'(host_status_o.filetype), 32'(attr[1:0]));
		end
		if (host_status_o.readonly !== exp_ro[0]) begin
			report_mismatch("readonly", 32'(host_status_o.readonly), exp_ro);
		end
		host_ctrl         = '0;
		host_ctrl.lba_sel = 1'b1;
		tick();
		if (host_data_o !== size) begin
			report_mismatch("host_data_o", host_data_o, size);
		end
		host_ctrl = '0;
		tick();
	endtask

	// Packet count in flag bits 15:8 with Y inversion in bit 4 and buttons in bits 1:0
	task automatic mouse_packets(input logic [31:0] dx, input logic [31:0] dy,
		input logic [31:0] flags, input logic [31:0] ex, input logic [31:0] ey);
		int          count;
		logic [13:0] joy_exp;
		count            = int'(flags[15:8]);
		mouse_invert_y_i = flags[4];
		for (int i = 0; i < count; i++) begin
			mouse_pkt.strobe  = ~mouse_pkt.strobe;
			mouse_pkt.dx      = dx[6:0];
			mouse_pkt.dx_sign = dx[7];
			mouse_pkt.dy      = dy[6:0];
			mouse_pkt.dy_sign = dy[7];
			mouse_pkt.buttons = flags[1:0];
			tick();
		end
		joy_exp = {JOY_IDLE[13:9], flags[1:0], JOY_IDLE[6:0]};
		if (axis_x_o !== ex[7:0]) begin
			report_mismatch("axis_x_o", 32'(axis_x_o), ex);
		end
		if (axis_y_o !== ey[7:0]) begin
			report_mismatch("axis_y_o", 32'(axis_y_o), ey);
		end
		if (joy_o !== joy_exp) begin
			report_mismatch("joy_o", 32'(joy_o), 32'(joy_exp));
		end
	endtask

	task automatic joystick_takeover(input logic [31:0] joya, input logic [31:0] halt);
		joya_i     = joya[15:0];
		cpu_halt_i = halt[0];
		tick();
		if (axis_x_o !== joya[7:0]) begin
			report_mismatch("axis_x_o", 32'(axis_x_o), 32'(joya[7:0]));
		end
		if (axis_y_o !== joya[15:8]) begin
			report_mismatch("axis_y_o", 32'(axis_y_o), 32'(joya[15:8]));
		end
		if (joy_o !== JOY_IDLE) begin
			report_mismatch("joy_o", 32'(joy_o), 32'(JOY_IDLE));
		end
		joya_i     = '0;
		cpu_halt_i = 1'b0;
		tick();
		if (axis_x_o !== 8'h00 || axis_y_o !== 8'h00) begin
			report_mismatch("axis_y_o/axis_x_o", 32'({axis_y_o, axis_x_o}), 32'h0);
		end
	endtask

	// ==============================
	// Main sequence
	// ==============================

	initial begin
		areset           = 1'b1;
		host_ctrl        = '0;
		host_data_i      = '0;
		host_data_wr_i   = 1'b0;
		host_data_rd_i   = 1'b0;
		host_io_wr_i     = 1'b0;
		sd_ack_i         = '0;
		sd_buff_addr_i   = '0;
		sd_buff_dout_i   = '0;
		sd_buff_wr_i     = 1'b0;
		img_mounted_i    = '0;
		img_readonly_i   = 1'b0;
		img_type_i       = '0;
		img_size_i       = '0;
		mouse_pkt        = '0;
		mouse_invert_y_i = 1'b0;
		joya_i           = '0;
		joy_i            = JOY_IDLE;
		cpu_halt_i       = 1'b0;
		errors           = 0;
		tests_run        = 0;
		tests_failed     = 0;
		timed_out        = 1'b0;
		exp_mounted      = 1'b0;
		run_done         = 1'b0;
		seed_word        = $urandom(6);
		$readmemh("tb/a8_io_patterns.txt", pat);

		repeat (10) tick();
		areset = 1'b0;
		tick();

		pat_line = 0;
		while (!run_done && pat_line < PAT_LINES) begin
			base = pat_line * PAT_COLS;
			op   = pat[base];
			if ($isunknown(op) || op == 32'h0) begin
				run_done = 1'b1;
			end else begin
				err_before = errors;
				case (op)
					32'h1: host_write_readback(int'(pat[base+1]));
					32'h2: host_read_sequence(int'(pat[base+1]));
					32'h3: block_request_cycle(pat[base+1][2:0], pat[base+2][0],
						pat[base+3], pat[base+4][3:0]);
					32'h4: mount_image(int'(pat[base+1]), pat[base+2], pat[base+3],
						pat[base+4], pat[base+5]);
					32'h5: mouse_packets(pat[base+1], pat[base+2], pat[base+3],
						pat[base+4], pat[base+5]);
					32'h6: joystick_takeover(pat[base+1], pat[base+2]);
					default: begin
						$display("Unknown operation code %h on pattern line %0d", op, pat_line);
						errors++;
					end
				endcase
				tests_run++;
				if (errors != err_before) begin
					tests_failed++;
					$display("test %0d %s: FAIL", tests_run, op_name(op));
				end else begin
					$display("test %0d %s: PASS", tests_run, op_name(op));
				end
				if (timed_out) begin
					run_done = 1'b1;
				end
			end
			pat_line++;
		end

		if (tests_run == 0) begin
			$display("No operations were read from the pattern file");
			errors++;
		end
		$display("tests run %0d, tests failed %0d, check errors %0d",
			tests_run, tests_failed, errors);
		if (errors == 0 && !timed_out) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

/* tb/tb_clock.sv */
// Testbench clock generator
`timescale 1ns/1ps

module tb_clock #(
	parameter real PERIOD_NS = 4.0
) (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
	end

endmodule

/* hdl/a8_io_top.sv */
// Top level of the a8_io block with disk bridge and mouse axis emulation
`timescale 1ns/1ps
`include "a8_io_params.svh"

module a8_io_top (
	input  logic                    clk_sys,
	input  logic                    areset,
	// Host mailbox
	input  a8_io_pkg::host_ctrl_t   host_ctrl_i,
	input  logic [`A8_WORD_W-1:0]   host_data_i,
	input  logic                    host_data_wr_i,
	input  logic                    host_data_rd_i,
	input  logic                    host_io_wr_i,
	output a8_io_pkg::host_status_t host_status_o,
	output logic [`A8_WORD_W-1:0]   host_data_o,
	// SD block side
	output logic [`A8_WORD_W-1:0]   sd_lba_o,
	output logic [`A8_NUM_DRV-1:0]  sd_rd_o,
	output logic [`A8_NUM_DRV-1:0]  sd_wr_o,
	input  logic [`A8_NUM_DRV-1:0]  sd_ack_i,
	input  logic [`A8_BUF_AW-1:0]   sd_buff_addr_i,
	input  logic [`A8_BYTE_W-1:0]   sd_buff_dout_i,
	input  logic                    sd_buff_wr_i,
	output logic [`A8_BYTE_W-1:0]   sd_buff_din_o,
	// Image mounts
	input  logic [`A8_NUM_DRV-1:0]  img_mounted_i,
	input  logic                    img_readonly_i,
	input  logic [1:0]              img_type_i,
	input  logic [`A8_WORD_W-1:0]   img_size_i,
	// Mouse and joystick
	input  a8_io_pkg::mouse_pkt_t   mouse_pkt_i,
	input  logic                    mouse_invert_y_i,
	input  logic [15:0]             joya_i,
	input  logic [13:0]             joy_i,
	input  logic                    cpu_halt_i,
	output logic [7:0]              axis_x_o,
	output logic [7:0]              axis_y_o,
	output logic [13:0]             joy_o
);

	logic       io_done;
	logic       mounted;
	logic [2:0] fileno;
	logic [1:0] filetype;
	logic       readonly;

	buf_port_if sd_buf ();
	buf_port_if host_buf ();

	// SD side of the buffer comes straight from the top ports
	assign sd_buf.addr   = sd_buff_addr_i;
	assign sd_buf.wdata  = sd_buff_dout_i;
	assign sd_buf.we     = sd_buff_wr_i;
	assign sd_buff_din_o = sd_buf.rdata;

	sector_buffer u_sector_buffer (
		.clk_sys   (clk_sys),
		.sd_port   (sd_buf.ram),
		.host_port (host_buf.ram)
	);

	host_mailbox u_host_mailbox (
		.clk_sys        (clk_sys),
		.areset         (areset),
		.host_ctrl_i    (host_ctrl_i),
		.host_data_i    (host_data_i),
		.host_data_wr_i (host_data_wr_i),
		.host_data_rd_i (host_data_rd_i),
		.host_io_wr_i   (host_io_wr_i),
		.sd_ack_i       (sd_ack_i),
		.buf_port       (host_buf.master),
		.sd_lba_o       (sd_lba_o),
		.sd_rd_o        (sd_rd_o),
		.sd_wr_o        (sd_wr_o),
		.io_done_o      (io_done)
	);

	mount_tracker u_mount_tracker (
		.clk_sys        (clk_sys),
		.areset         (areset),
		.img_mounted_i  (img_mounted_i),
		.img_readonly_i (img_readonly_i),
		.img_type_i     (img_type_i),
		.img_size_i     (img_size_i),
		.lba_sel_i      (host_ctrl_i.lba_sel),
		.buf_byte_i     (host_buf.rdata),
		.mounted_o      (mounted),
		.fileno_o       (fileno),
		.filetype_o     (filetype),
		.readonly_o     (readonly),
		.host_data_o    (host_data_o)
	);

	mouse_axis u_mouse_axis (
		.clk_sys          (clk_sys),
		.areset           (areset),
		.mouse_pkt_i      (mouse_pkt_i),
		.mouse_invert_y_i (mouse_invert_y_i),
		.joya_i           (joya_i),
		.joy_i            (joy_i),
		.cpu_halt_i       (cpu_halt_i),
		.axis_x_o         (axis_x_o),
		.axis_y_o         (axis_y_o),
		.joy_o            (joy_o)
	);

	assign host_status_o = '{
		readonly: readonly,
		filetype: filetype,
		fileno:   fileno,
		mounted:  mounted,
		io_done:  io_done
	};

endmodule

/* hdl/mouse_axis.sv */
// Mouse axis emulation with delta clamping, axis accumulation and joystick select
`timescale 1ns/1ps
`include "a8_io_params.svh"

module mouse_axis (
	input  logic                  clk_sys,
	input  logic                  areset,
	input  a8_io_pkg::mouse_pkt_t mouse_pkt_i,
	input  logic                  mouse_invert_y_i,
	input  logic [15:0]           joya_i,
	input  logic [13:0]           joy_i,
	input  logic                  cpu_halt_i,
	output logic [7:0]            axis_x_o,
	output logic [7:0]            axis_y_o,
	output logic [13:0]           joy_o
);

	import a8_io_pkg::*;

	axis_t mx;
	axis_t my;
	axis_t mdx;
	axis_t mdy;
	axis_t nmx;
	axis_t nmy;
	logic  emu;
	logic  stb_d1;

	function automatic axis_t sat(input axis_t v, input int lo, input int hi);
		if (v < lo) begin
			return axis_t'(lo);
		end
		if (v > hi) begin
			return axis_t'(hi);
		end
		return v;
	endfunction

	// ==============================
	// Next axis values
	// ==============================

	assign mdx = sat({mouse_pkt_i.dx_sign, mouse_pkt_i.dx_sign, mouse_pkt_i.dx},
		-`A8_MDELTA_MAX, `A8_MDELTA_MAX);
	assign mdy = sat({mouse_pkt_i.dy_sign, mouse_pkt_i.dy_sign, mouse_pkt_i.dy},
		-`A8_MDELTA_MAX, `A8_MDELTA_MAX);
	assign nmx = mx + mdx;
	assign nmy = mouse_invert_y_i ? (my - mdy) : (my + mdy);

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			stb_d1 <= 1'b0;
			emu    <= 1'b0;
			mx     <= '0;
			my     <= '0;
		end else begin
			stb_d1 <= mouse_pkt_i.strobe;
			// Each toggle of the strobe is a new packet
			if (stb_d1 != mouse_pkt_i.strobe) begin
				emu <= 1'b1;
				mx  <= sat(nmx, `A8_AXIS_MIN, `A8_AXIS_MAX);
				my  <= sat(nmy, `A8_AXIS_MIN, `A8_AXIS_MAX);
			end
			// Real stick movement or a halted CPU hands control back
			if ((|joya_i) || cpu_halt_i) begin
				emu <= 1'b0;
				mx  <= '0;
				my  <= '0;
			end
		end
	end

	assign axis_x_o = emu ? mx[7:0] : joya_i[7:0];
	assign axis_y_o = emu ? my[7:0] : joya_i[15:8];
	assign joy_o    = {joy_i[13:9], emu ? mouse_pkt_i.buttons : joy_i[8:7], joy_i[6:0]};

endmodule

/* hdl/mount_tracker.sv */
// Image mount tracker with file attributes, size register and host data select
`timescale 1ns/1ps
`include "a8_io_params.svh"

module mount_tracker (
	input  logic                   clk_sys,
	input  logic                   areset,
	input  logic [`A8_NUM_DRV-1:0] img_mounted_i,
	input  logic                   img_readonly_i,
	input  logic [1:0]             img_type_i,
	input  logic [`A8_WORD_W-1:0]  img_size_i,
	input  logic                   lba_sel_i,
	input  logic [`A8_BYTE_W-1:0]  buf_byte_i,
	output logic                   mounted_o,
	output logic [2:0]             fileno_o,
	output logic [1:0]             filetype_o,
	output logic                   readonly_o,
	output logic [`A8_WORD_W-1:0]  host_data_o
);

	logic                  mnt_d1;
	logic                  mnt_rise;
	logic [1:0]            slot_sel;
	logic [`A8_WORD_W-1:0] file_size;

	assign mnt_rise = |img_mounted_i & ~mnt_d1;

	// Highest mounted slot wins
	always_comb begin
		slot_sel = '0;
		for (int i = 0; i < `A8_NUM_DRV; i++) begin
			if (img_mounted_i[i]) begin
				slot_sel = i[1:0];
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			mnt_d1     <= 1'b0;
			mounted_o  <= 1'b0;
			fileno_o   <= '0;
			filetype_o <= '0;
			readonly_o <= 1'b0;
			file_size  <= '0;
		end else begin
			mnt_d1 <= |img_mounted_i;
			if (mnt_rise) begin
				// Slots 0 to 3 map to file numbers 0, 1, 4, 5
				fileno_o   <= {slot_sel[1], 1'b0, slot_sel[0]};
				filetype_o <= img_type_i;
				readonly_o <= img_readonly_i | (|img_mounted_i[3:2]);
				mounted_o  <= ~mounted_o;
				file_size  <= img_size_i;
			end
		end
	end

	// Size while the host asks for the LBA and the buffer byte otherwise
	assign host_data_o = lba_sel_i ? file_size :
		{{(`A8_WORD_W-`A8_BYTE_W){1'b0}}, buf_byte_i};

endmodule

/* hdl/host_mailbox.sv */
// Host mailbox with strobe edge detection, buffer address, LBA capture and block requests
`timescale 1ns/1ps
`include "a8_io_params.svh"

module host_mailbox (
	input  logic                   clk_sys,
	input  logic                   areset,
	input  a8_io_pkg::host_ctrl_t  host_ctrl_i,
	input  logic [`A8_WORD_W-1:0]  host_data_i,
	input  logic                   host_data_wr_i,
	input  logic                   host_data_rd_i,
	input  logic                   host_io_wr_i,
	input  logic [`A8_NUM_DRV-1:0] sd_ack_i,
	buf_port_if.master             buf_port,
	output logic [`A8_WORD_W-1:0]  sd_lba_o,
	output logic [`A8_NUM_DRV-1:0] sd_rd_o,
	output logic [`A8_NUM_DRV-1:0] sd_wr_o,
	output logic                   io_done_o
);

	logic wr_d1;
	logic wr_d2;
	logic rd_d1;
	logic blrd_d1;
	logic blwr_d1;
	logic ack_d1;
	logic data_wr_det;
	logic data_rd_fall;
	logic blrd_rise;
	logic blwr_rise;
	logic ack_any;
	logic ack_fall;
	logic buf_wr;
	logic [`A8_BUF_AW-1:0] buf_addr;
	logic [$clog2(`A8_NUM_DRV)-1:0] drv_idx;

	// ==============================
	// Strobe edge detection
	// ==============================

	// Data write is seen one cycle late, so the host data has settled
	assign data_wr_det  = wr_d1 & ~wr_d2;
	assign data_rd_fall = rd_d1 & ~host_data_rd_i;
	assign blrd_rise    = host_ctrl_i.block_rd & ~blrd_d1;
	assign blwr_rise    = host_ctrl_i.block_wr & ~blwr_d1;
	assign ack_any      = |sd_ack_i;
	assign ack_fall     = ack_d1 & ~ack_any;

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			wr_d1   <= 1'b0;
			wr_d2   <= 1'b0;
			rd_d1   <= 1'b0;
			blrd_d1 <= 1'b0;
			blwr_d1 <= 1'b0;
			ack_d1  <= 1'b0;
		end else begin
			wr_d1   <= host_data_wr_i;
			wr_d2   <= wr_d1;
			rd_d1   <= host_data_rd_i;
			blrd_d1 <= host_ctrl_i.block_rd;
			blwr_d1 <= host_ctrl_i.block_wr;
			ack_d1  <= ack_any;
		end
	end

	// ==============================
	// Buffer address and data
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			buf_wr   <= 1'b0;
			buf_addr <= '0;
		end else begin
			buf_wr <= data_wr_det & ~host_ctrl_i.lba_sel;
			if (buf_wr || data_rd_fall) begin
				buf_addr <= buf_addr + 1'b1;
			end
			// Clear from the host beats any increment
			if (host_io_wr_i) begin
				buf_addr <= '0;
			end
		end
	end

	assign buf_port.addr  = buf_addr;
	assign buf_port.wdata = host_data_i[`A8_BYTE_W-1:0];
	assign buf_port.we    = buf_wr;

	always_ff @(posedge clk_sys) begin
		if (data_wr_det && host_ctrl_i.lba_sel) begin
			sd_lba_o <= host_data_i;
		end
	end

	// ==============================
	// Block requests
	// ==============================

	// Slot index from drive number bits 2 and 0
	assign drv_idx = {host_ctrl_i.drv_num[2], host_ctrl_i.drv_num[0]};

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			sd_rd_o   <= '0;
			sd_wr_o   <= '0;
			io_done_o <= 1'b0;
		end else begin
			if (blrd_rise) begin
				sd_rd_o[drv_idx] <= 1'b1;
			end
			if (blwr_rise) begin
				sd_wr_o[drv_idx] <= 1'b1;
			end
			if (blrd_rise || blwr_rise) begin
				io_done_o <= 1'b0;
			end
			// Any ack drops every pending request
			if (ack_any) begin
				sd_rd_o <= '0;
				sd_wr_o <= '0;
			end
			if (ack_fall) begin
				io_done_o <= 1'b1;
			end
		end
	end

endmodule

/* hdl/sector_buffer.sv */
// Sector buffer as a 512x8 true dual-port RAM for the SD side and the host side
`timescale 1ns/1ps
`include "a8_io_params.svh"

module sector_buffer (
	input  logic    clk_sys,
	buf_port_if.ram sd_port,
	buf_port_if.ram host_port
);

	localparam int DEPTH = 1 << `A8_BUF_AW;

	logic [`A8_BYTE_W-1:0] mem [DEPTH];

	// ==============================
	// Writes from both ports
	// ==============================

	// A host write wins if both ports hit the same byte
	always_ff @(posedge clk_sys) begin
		if (sd_port.we) begin
			mem[sd_port.addr] <= sd_port.wdata;
		end
		if (host_port.we) begin
			mem[host_port.addr] <= host_port.wdata;
		end
	end

	// ==============================
	// Registered reads
	// ==============================

	// Old data is returned on a same-cycle write
	always_ff @(posedge clk_sys) begin
		sd_port.rdata <= mem[sd_port.addr];
	end

	always_ff @(posedge clk_sys) begin
		host_port.rdata <= mem[host_port.addr];
	end

endmodule

/* hdl/buf_port_if.sv */
// Interface for one sector buffer port with master and RAM modports
`timescale 1ns/1ps
`include "a8_io_params.svh"

interface buf_port_if;

	logic [`A8_BUF_AW-1:0] addr;
	logic [`A8_BYTE_W-1:0] wdata;
	logic                  we;
	logic [`A8_BYTE_W-1:0] rdata;

	// Side that owns the address
	modport master (
		output addr,
		output wdata,
		output we,
		input  rdata
	);

	modport ram (
		input  addr,
		input  wdata,
		input  we,
		output rdata
	);

endinterface

/* hdl/a8_io_pkg.sv */
// Package with host control, host status, mouse packet and axis types
package a8_io_pkg;

	// Host control word with lba_sel in bit 0
	typedef struct packed {
		logic [1:0] spare;
		logic [2:0] drv_num;
		logic       block_wr;
		logic       block_rd;
		logic       lba_sel;
	} host_ctrl_t;

	// Status byte read back by the host with io_done in bit 0
	typedef struct packed {
		logic       readonly;
		logic [1:0] filetype;
		logic [2:0] fileno;
		logic       mounted;
		logic       io_done;
	} host_status_t;

	// 25-bit PS/2 mouse packet as delivered by the host
	typedef struct packed {
		logic       strobe;
		logic [6:0] dy;
		logic       dy_lsb;
		logic [6:0] dx;
		logic       dx_lsb;
		logic [1:0] ovf;
		logic       dy_sign;
		logic       dx_sign;
		logic [1:0] btn_hi;
		logic [1:0] buttons;
	} mouse_pkt_t;

	// Signed axis accumulator with one bit of headroom over a byte
	typedef logic signed [8:0] axis_t;

endpackage

/* hdl/a8_io_params.svh */
// Widths and constants shared by the a8_io design and its testbench
`ifndef A8_IO_PARAMS_SVH
`define A8_IO_PARAMS_SVH

// ==============================
// Sector buffer
// ==============================

// 512 bytes per sector
`define A8_BUF_AW 9
`define A8_BYTE_W 8

// ==============================
// Host mailbox and SD slots
// ==============================

`define A8_WORD_W 32
`define A8_NUM_DRV 4

// ==============================
// Mouse axis emulation
// ==============================

// Largest single step taken from one packet
`define A8_MDELTA_MAX 10
`define A8_AXIS_MIN (-128)
`define A8_AXIS_MAX 127

`endif
